//--- rtl/branch_resolver.sv
`timescale 1ns/1ps
`include "id_defines.svh"

module branch_resolver (
  input logic valid,
  input isa_pkg::instruction_t instruction,
  input decode_pkg::branch_kind_t branch_kind,
  input isa_pkg::word_t program_count,
  input isa_pkg::word_t source_value,
  input isa_pkg::word_t target_value,
  output logic branch_taken,
  output isa_pkg::word_t branch_target
);
  import isa_pkg::*;
  import decode_pkg::*;

  word_t delay_slot;
  word_t branch_offset;
  logic operands_equal;

  assign delay_slot = program_count + word_t'(4);
  assign branch_offset = {{(`DATA_WIDTH - 18){instruction.i_view.immediate[15]}},
                          instruction.i_view.immediate, 2'b00};
  assign operands_equal = source_value == target_value;

  always_comb begin
    case (branch_kind)
      BRANCH_BEQ: branch_taken = valid && operands_equal;
      BRANCH_BNE: branch_taken = valid && !operands_equal;
      BRANCH_JUMP, BRANCH_JUMP_REGISTER: branch_taken = valid;
      default: branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (branch_kind)
      BRANCH_BEQ, BRANCH_BNE: branch_target = delay_slot + branch_offset;
      BRANCH_JUMP_REGISTER: branch_target = source_value;
      default: branch_target = {delay_slot[`DATA_WIDTH-1 -: 4],
                                instruction.j_view.jump_index, 2'b00};
    endcase
  end
endmodule

//--- rtl/decode_pkg.sv
package decode_pkg;

  localparam int ALU_OP_COUNT = 12;

  // Bit positions inside the one-hot ALU operation vector.
  localparam int ALU_ADD = 0;
  localparam int ALU_SUB = 1;
  localparam int ALU_SLT = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND = 4;
  localparam int ALU_NOR = 5;
  localparam int ALU_OR = 6;
  localparam int ALU_XOR = 7;
  localparam int ALU_SLL = 8;
  localparam int ALU_SRL = 9;
  localparam int ALU_SRA = 10;
  localparam int ALU_LUI = 11;

  typedef logic [ALU_OP_COUNT-1:0] alu_operation_t;

  typedef enum logic [2:0] {
    BRANCH_NONE,
    BRANCH_BEQ,
    BRANCH_BNE,
    BRANCH_JUMP,
    BRANCH_JUMP_REGISTER
  } branch_kind_t;

endpackage

//--- rtl/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

`define DATA_WIDTH 32
`define REG_COUNT 32
`define REG_INDEX_WIDTH 5
`define LINK_REGISTER 5'd31

// Primary opcodes.
`define OP_SPECIAL 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDIU 6'h09
`define OP_SLTI 6'h0a
`define OP_SLTIU 6'h0b
`define OP_ANDI 6'h0c
`define OP_ORI 6'h0d
`define OP_XORI 6'h0e
`define OP_LUI 6'h0f
`define OP_LW 6'h23
`define OP_SW 6'h2b

// Function codes under OP_SPECIAL.
`define FUNCT_SLL 6'h00
`define FUNCT_SRL 6'h02
`define FUNCT_SRA 6'h03
`define FUNCT_JR 6'h08
`define FUNCT_ADDU 6'h21
`define FUNCT_SUBU 6'h23
`define FUNCT_AND 6'h24
`define FUNCT_OR 6'h25
`define FUNCT_XOR 6'h26
`define FUNCT_NOR 6'h27
`define FUNCT_SLT 6'h2a
`define FUNCT_SLTU 6'h2b

`endif

//--- rtl/id_interfaces.sv
`timescale 1ns/1ps

interface bypass_if;
  import isa_pkg::*;

  logic valid;
  logic data_valid; // Low while the producing instruction has no result yet.
  register_index_t write_register;
  word_t write_data;

  modport consumer (
    input valid,
    input data_valid,
    input write_register,
    input write_data
  );
endinterface

interface read_port_if;
  import isa_pkg::*;

  register_index_t source_index;
  register_index_t target_index;
  word_t source_data;
  word_t target_data;

  modport requester (output source_index, output target_index,
                     input source_data, input target_data);
  modport responder (input source_index, input target_index,
                     output source_data, output target_data);
endinterface

//--- rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input logic clock,
  input logic reset,
  input logic if_valid,
  input isa_pkg::instruction_t if_instruction,
  input isa_pkg::word_t if_program_count,
  output logic id_allow_in,
  input logic ex_allow_in,
  input logic ex_valid,
  input logic ex_data_valid,
  input isa_pkg::register_index_t ex_write_register,
  input isa_pkg::word_t ex_write_data,
  input logic wb_valid,
  input isa_pkg::register_index_t wb_write_register,
  input isa_pkg::word_t wb_write_data,
  output logic decode_valid,
  output isa_pkg::word_t decode_program_count,
  output isa_pkg::word_t decode_source_value,
  output isa_pkg::word_t decode_target_value,
  output logic [15:0] decode_immediate,
  output isa_pkg::register_index_t decode_write_register,
  output logic decode_register_write,
  output logic decode_memory_write,
  output logic decode_is_load,
  output decode_pkg::alu_operation_t decode_alu_operation,
  output logic decode_source1_is_shift_amount,
  output logic decode_source1_is_program_count,
  output logic decode_source2_is_immediate,
  output logic decode_source2_is_unsigned,
  output logic decode_source2_is_8,
  output logic branch_taken,
  output isa_pkg::word_t branch_target
);
  import isa_pkg::*;
  import decode_pkg::*;

  logic id_valid;
  instruction_t instruction_latch;
  word_t program_count_latch;
  register_index_t source_index;
  register_index_t target_index;
  logic target_used;
  logic stall;
  branch_kind_t branch_kind;

  bypass_if ex_bypass ();
  bypass_if wb_bypass ();
  read_port_if read_port ();

  assign ex_bypass.valid = ex_valid;
  assign ex_bypass.data_valid = ex_data_valid;
  assign ex_bypass.write_register = ex_write_register;
  assign ex_bypass.write_data = ex_write_data;
  assign wb_bypass.valid = wb_valid;
  assign wb_bypass.data_valid = 1'b1; // Write-back data is always final.
  assign wb_bypass.write_register = wb_write_register;
  assign wb_bypass.write_data = wb_write_data;

  assign id_allow_in = !id_valid || (!stall && ex_allow_in);
  assign decode_valid = id_valid && !stall;
  assign decode_program_count = program_count_latch;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (id_allow_in) begin
      id_valid <= if_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (if_valid && id_allow_in) begin
      instruction_latch <= if_instruction;
      program_count_latch <= if_program_count;
    end
  end

  instruction_decoder u_decoder (
    .instruction(instruction_latch),
    .source_index(source_index),
    .target_index(target_index),
    .target_used(target_used),
    .immediate(decode_immediate),
    .write_register(decode_write_register),
    .register_write(decode_register_write),
    .memory_write(decode_memory_write),
    .is_load(decode_is_load),
    .alu_operation(decode_alu_operation),
    .source1_is_shift_amount(decode_source1_is_shift_amount),
    .source1_is_program_count(decode_source1_is_program_count),
    .source2_is_immediate(decode_source2_is_immediate),
    .source2_is_unsigned(decode_source2_is_unsigned),
    .source2_is_8(decode_source2_is_8),
    .branch_kind(branch_kind)
  );

  register_file u_register_file (
    .clock(clock),
    .reset(reset),
    .read(read_port),
    .write(wb_bypass)
  );

  operand_forward u_forward (
    .source_index(source_index),
    .target_index(target_index),
    .target_used(target_used),
    .read(read_port),
    .ex_bypass(ex_bypass),
    .wb_bypass(wb_bypass),
    .source_value(decode_source_value),
    .target_value(decode_target_value),
    .stall(stall)
  );

  branch_resolver u_branch (
    .valid(id_valid),
    .instruction(instruction_latch),
    .branch_kind(branch_kind),
    .program_count(program_count_latch),
    .source_value(decode_source_value),
    .target_value(decode_target_value),
    .branch_taken(branch_taken),
    .branch_target(branch_target)
  );

  // An empty stage takes whatever fetch offers on the next edge.
  assert property (@(posedge clock) disable iff (reset)
    !id_valid |=> id_valid == $past(if_valid))
    else $error("empty stage did not accept from fetch");
endmodule

//--- rtl/instruction_decoder.sv
`timescale 1ns/1ps
`include "id_defines.svh"

module instruction_decoder (
  input isa_pkg::instruction_t instruction,
  output isa_pkg::register_index_t source_index,
  output isa_pkg::register_index_t target_index,
  output logic target_used,
  output logic [15:0] immediate,
  output isa_pkg::register_index_t write_register,
  output logic register_write,
  output logic memory_write,
  output logic is_load,
  output decode_pkg::alu_operation_t alu_operation,
  output logic source1_is_shift_amount,
  output logic source1_is_program_count,
  output logic source2_is_immediate,
  output logic source2_is_unsigned,
  output logic source2_is_8,
  output decode_pkg::branch_kind_t branch_kind
);
  import decode_pkg::*;

  logic special;
  logic op_addu, op_subu, op_and, op_or, op_xor, op_nor, op_slt, op_sltu;
  logic op_sll, op_srl, op_sra, op_jr;
  logic op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_lui;
  logic op_lw, op_sw, op_beq, op_bne, op_j, op_jal;
  logic register_register;
  logic target_is_destination;

  assign special = instruction.r_view.opcode == `OP_SPECIAL;

  assign op_addu = special && instruction.r_view.funct == `FUNCT_ADDU;
  assign op_subu = special && instruction.r_view.funct == `FUNCT_SUBU;
  assign op_and = special && instruction.r_view.funct == `FUNCT_AND;
  assign op_or = special && instruction.r_view.funct == `FUNCT_OR;
  assign op_xor = special && instruction.r_view.funct == `FUNCT_XOR;
  assign op_nor = special && instruction.r_view.funct == `FUNCT_NOR;
  assign op_slt = special && instruction.r_view.funct == `FUNCT_SLT;
  assign op_sltu = special && instruction.r_view.funct == `FUNCT_SLTU;
  assign op_sll = special && instruction.r_view.funct == `FUNCT_SLL;
  assign op_srl = special && instruction.r_view.funct == `FUNCT_SRL;
  assign op_sra = special && instruction.r_view.funct == `FUNCT_SRA;
  assign op_jr = special && instruction.r_view.funct == `FUNCT_JR;

  assign op_addiu = instruction.i_view.opcode == `OP_ADDIU;
  assign op_andi = instruction.i_view.opcode == `OP_ANDI;
  assign op_ori = instruction.i_view.opcode == `OP_ORI;
  assign op_xori = instruction.i_view.opcode == `OP_XORI;
  assign op_slti = instruction.i_view.opcode == `OP_SLTI;
  assign op_sltiu = instruction.i_view.opcode == `OP_SLTIU;
  assign op_lui = instruction.i_view.opcode == `OP_LUI;
  assign op_lw = instruction.i_view.opcode == `OP_LW;
  assign op_sw = instruction.i_view.opcode == `OP_SW;
  assign op_beq = instruction.i_view.opcode == `OP_BEQ;
  assign op_bne = instruction.i_view.opcode == `OP_BNE;
  assign op_j = instruction.j_view.opcode == `OP_J;
  assign op_jal = instruction.j_view.opcode == `OP_JAL;

  assign register_register = op_addu | op_subu | op_and | op_or | op_xor | op_nor |
                             op_slt | op_sltu | op_sll | op_srl | op_sra;
  assign target_is_destination = op_addiu | op_andi | op_ori | op_xori | op_slti |
                                 op_sltiu | op_lui | op_lw;

  assign source_index = instruction.r_view.rs;
  assign target_index = instruction.r_view.rt;
  assign immediate = instruction.i_view.immediate;
  assign target_used = register_register | op_beq | op_bne | op_sw;

  assign write_register = op_jal ? `LINK_REGISTER :
                          target_is_destination ? instruction.i_view.rt :
                          instruction.r_view.rd;
  assign register_write = ~(op_sw | op_beq | op_bne | op_j | op_jr);
  assign memory_write = op_sw;
  assign is_load = op_lw;

  assign alu_operation[ALU_ADD] = op_addu | op_addiu | op_jal | op_lw | op_sw;
  assign alu_operation[ALU_SUB] = op_subu;
  assign alu_operation[ALU_SLT] = op_slt | op_slti;
  assign alu_operation[ALU_SLTU] = op_sltu | op_sltiu;
  assign alu_operation[ALU_AND] = op_and | op_andi;
  assign alu_operation[ALU_NOR] = op_nor;
  assign alu_operation[ALU_OR] = op_or | op_ori;
  assign alu_operation[ALU_XOR] = op_xor | op_xori;
  assign alu_operation[ALU_SLL] = op_sll;
  assign alu_operation[ALU_SRL] = op_srl;
  assign alu_operation[ALU_SRA] = op_sra;
  assign alu_operation[ALU_LUI] = op_lui;

  assign source1_is_shift_amount = op_sll | op_srl | op_sra;
  assign source1_is_program_count = op_jal; // Link value is pc + 8.
  assign source2_is_8 = op_jal;
  assign source2_is_immediate = target_is_destination | op_sw;
  assign source2_is_unsigned = op_andi | op_ori | op_xori; // Logical ops zero-extend.

  assign branch_kind = op_beq ? BRANCH_BEQ :
                       op_bne ? BRANCH_BNE :
                       (op_j | op_jal) ? BRANCH_JUMP :
                       op_jr ? BRANCH_JUMP_REGISTER :
                       BRANCH_NONE;

  always_comb begin
    assert ($onehot0(alu_operation))
      else $error("alu_operation %b is not one-hot", alu_operation);
  end
endmodule

//--- rtl/isa_pkg.sv
`include "id_defines.svh"

package isa_pkg;

  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [`REG_INDEX_WIDTH-1:0] register_index_t;

  typedef struct packed {
    logic [5:0] opcode;
    register_index_t rs;
    register_index_t rt;
    register_index_t rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_format_t;

  typedef struct packed {
    logic [5:0] opcode;
    register_index_t rs;
    register_index_t rt;
    logic [15:0] immediate;
  } i_format_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [25:0] jump_index;
  } j_format_t;

  // The opcode sits in the same six bits in every view.
  typedef union packed {
    r_format_t r_view;
    i_format_t i_view;
    j_format_t j_view;
  } instruction_t;

endpackage

//--- rtl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
  input isa_pkg::register_index_t source_index,
  input isa_pkg::register_index_t target_index,
  input logic target_used,
  read_port_if.requester read,
  bypass_if.consumer ex_bypass,
  bypass_if.consumer wb_bypass,
  output isa_pkg::word_t source_value,
  output isa_pkg::word_t target_value,
  output logic stall
);
  import isa_pkg::*;

  logic ex_pending;
  logic source_waits;
  logic target_waits;

  // Execute is newer than write-back, so it wins when both match.
  function automatic word_t forward(register_index_t index, word_t file_data);
    if (index != '0 && ex_bypass.valid && ex_bypass.data_valid &&
        ex_bypass.write_register == index) begin
      return ex_bypass.write_data;
    end else if (index != '0 && wb_bypass.valid && wb_bypass.data_valid &&
                 wb_bypass.write_register == index) begin
      return wb_bypass.write_data;
    end
    return file_data;
  endfunction

  assign read.source_index = source_index;
  assign read.target_index = target_index;

  assign source_value = forward(source_index, read.source_data);
  assign target_value = forward(target_index, read.target_data);

  // An execute result that is not ready yet, typically a load.
  assign ex_pending = ex_bypass.valid && !ex_bypass.data_valid &&
                      ex_bypass.write_register != '0;
  assign source_waits = ex_bypass.write_register == source_index;
  assign target_waits = target_used && ex_bypass.write_register == target_index;
  assign stall = ex_pending && (source_waits || target_waits);
endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps
`include "id_defines.svh"

module register_file (
  input logic clock,
  input logic reset,
  read_port_if.responder read,
  bypass_if.consumer write
);
  import isa_pkg::*;

  word_t registers [1:`REG_COUNT-1]; // Register 0 has no storage.

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        registers[i] <= '0;
      end
    end else if (write.valid && write.write_register != '0) begin
      registers[write.write_register] <= write.write_data;
    end
  end

  assign read.source_data = (read.source_index == '0) ? '0 : registers[read.source_index];
  assign read.target_data = (read.target_index == '0) ? '0 : registers[read.target_index];

  // A written word reads back on the next cycle, and register 0 keeps reading zero.
  assert property (@(posedge clock) disable iff (reset)
    write.valid |=> (read.source_index != $past(write.write_register) ||
                     read.source_data == (($past(write.write_register) == '0) ? '0 :
                                          $past(write.write_data))))
    else $error("register file read back a wrong word");
endmodule

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and decide by searching the log.
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_id_stage -f sim.f \
  && ./obj_dir/Vtb_id_stage > sim.log 2>&1 \
  || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/decode_pkg.sv
rtl/id_interfaces.sv
rtl/instruction_decoder.sv
rtl/register_file.sv
rtl/operand_forward.sv
rtl/branch_resolver.sv
rtl/id_stage.sv
tests/tb_id_stage.sv

//--- tests/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
  localparam int INSTRUCTION_COUNT = 400;
  localparam int CYCLE_LIMIT = 8000;
  localparam int DRAIN_LIMIT = 20;

  typedef struct packed {
    logic [4:0] kind;
    logic [31:0] word;
    logic [31:0] pc;
  } staged_t;

  logic clock = 1'b0;
  logic reset;
  logic if_valid;
  logic [31:0] if_instruction;
  logic [31:0] if_program_count;
  logic id_allow_in;
  logic ex_allow_in;
  logic ex_valid;
  logic ex_data_valid;
  logic [4:0] ex_write_register;
  logic [31:0] ex_write_data;
  logic wb_valid;
  logic [4:0] wb_write_register;
  logic [31:0] wb_write_data;
  logic decode_valid;
  logic [31:0] decode_program_count;
  logic [31:0] decode_source_value;
  logic [31:0] decode_target_value;
  logic [15:0] decode_immediate;
  logic [4:0] decode_write_register;
  logic decode_register_write;
  logic decode_memory_write;
  logic decode_is_load;
  logic [11:0] decode_alu_operation;
  logic decode_source1_is_shift_amount;
  logic decode_source1_is_program_count;
  logic decode_source2_is_immediate;
  logic decode_source2_is_unsigned;
  logic decode_source2_is_8;
  logic branch_taken;
  logic [31:0] branch_target;

  logic [31:0] shadow [0:31];
  staged_t stage [$]; // Holds at most the one instruction in the stage.
  logic expected_allow_in;
  int current_kind;
  int accepted = 0;

  id_stage u_dut (.*);

  always #2 clock = ~clock;

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // Kinds 0 to 11 are SPECIAL forms, 12 to 22 use the I format, 23 and 24 are j and jal.
  function automatic logic [11:0] opcode_funct(input int kind);
    case (kind)
      0: return {6'h00, 6'h21}; // addu
      1: return {6'h00, 6'h23}; // subu
      2: return {6'h00, 6'h24}; // and
      3: return {6'h00, 6'h25}; // or
      4: return {6'h00, 6'h26}; // xor
      5: return {6'h00, 6'h27}; // nor
      6: return {6'h00, 6'h2a}; // slt
      7: return {6'h00, 6'h2b}; // sltu
      8: return {6'h00, 6'h00}; // sll
      9: return {6'h00, 6'h02}; // srl
      10: return {6'h00, 6'h03}; // sra
      11: return {6'h00, 6'h08}; // jr
      12: return {6'h09, 6'h00}; // addiu
      13: return {6'h0c, 6'h00}; // andi
      14: return {6'h0d, 6'h00}; // ori
      15: return {6'h0e, 6'h00}; // xori
      16: return {6'h0a, 6'h00}; // slti
      17: return {6'h0b, 6'h00}; // sltiu
      18: return {6'h0f, 6'h00}; // lui
      19: return {6'h23, 6'h00}; // lw
      20: return {6'h2b, 6'h00}; // sw
      21: return {6'h04, 6'h00}; // beq
      22: return {6'h05, 6'h00}; // bne
      23: return {6'h02, 6'h00}; // j
      default: return {6'h03, 6'h00}; // jal
    endcase
  endfunction

  // Returns the one-hot ALU bit in the reference order, or -1 when no ALU operation applies.
  function automatic int alu_bit(input int kind);
    case (kind)
      0, 12, 19, 20, 24: return 0;
      1: return 1;
      6, 16: return 2;
      7, 17: return 3;
      2, 13: return 4;
      5: return 5;
      3, 14: return 6;
      4, 15: return 7;
      8: return 8;
      9: return 9;
      10: return 10;
      18: return 11;
      default: return -1;
    endcase
  endfunction

  function automatic logic [31:0] encode_instruction(input int kind);
    logic [11:0] codes;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    codes = opcode_funct(kind);
    rs = 5'($urandom_range(7, 0)); // A few registers only, so hazards are frequent.
    rt = 5'($urandom_range(7, 0));
    rd = 5'($urandom_range(7, 0));
    if (kind >= 23) return {codes[11:6], 26'($urandom)};
    if (kind <= 11) return {6'h00, rs, rt, rd, 5'($urandom_range(31, 0)), codes[5:0]};
    return {codes[11:6], rs, rt, 16'($urandom)};
  endfunction

  function automatic logic [31:0] forward_value(input logic [4:0] index);
    if (index == 5'd0) return 32'd0;
    if (ex_valid && ex_data_valid && ex_write_register == index) return ex_write_data;
    if (wb_valid && wb_write_register == index) return wb_write_data;
    return shadow[index];
  endfunction

  task automatic drive_inputs();
    current_kind = int'($urandom_range(24, 0));
    if_valid = $urandom_range(9, 0) < 8;
    if_instruction = encode_instruction(current_kind);
    if_program_count = $urandom & ~32'h3;
    ex_allow_in = $urandom_range(4, 0) != 0;
    ex_valid = $urandom_range(9, 0) < 7;
    ex_data_valid = $urandom_range(3, 0) != 0; // Low marks a load still in flight.
    ex_write_register = 5'($urandom_range(7, 0));
    ex_write_data = $urandom;
    wb_valid = $urandom_range(9, 0) < 7;
    wb_write_register = 5'($urandom_range(7, 0));
    wb_write_data = $urandom;
  endtask

  task automatic check_outputs();
    staged_t s;
    logic stage_valid;
    logic target_used;
    logic stall;
    logic equal;
    logic taken;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] write_register;
    logic [31:0] source;
    logic [31:0] target;
    logic [31:0] delay_slot;
    logic [31:0] jump_target;
    int k;
    int bit_index;
    stage_valid = stage.size() != 0;
    s = stage_valid ? stage[0] : '0;
    k = int'(s.kind);
    rs = s.word[25:21];
    rt = s.word[20:16];
    target_used = k <= 10 || k inside {20, 21, 22};
    stall = ex_valid && !ex_data_valid && ex_write_register != 5'd0 &&
            (ex_write_register == rs || (target_used && ex_write_register == rt));
    expected_allow_in = !stage_valid || (!stall && ex_allow_in);
    source = forward_value(rs);
    target = forward_value(rt);
    equal = source == target;
    taken = stage_valid && ((k == 21 && equal) || (k == 22 && !equal) || k inside {11, 23, 24});
    compare_value("id_allow_in", 32'(id_allow_in), 32'(expected_allow_in));
    compare_value("decode_valid", 32'(decode_valid), 32'(stage_valid && !stall));
    compare_value("branch_taken", 32'(branch_taken), 32'(taken));
    if (stage_valid && k inside {11, 21, 22, 23, 24}) begin
      delay_slot = s.pc + 32'd4;
      if (k == 11) jump_target = source;
      else if (k >= 23) jump_target = {delay_slot[31:28], s.word[25:0], 2'b00};
      else jump_target = delay_slot + {{14{s.word[15]}}, s.word[15:0], 2'b00};
      compare_value("branch_target", branch_target, jump_target);
    end
    if (stage_valid && !stall) begin
      bit_index = alu_bit(k);
      write_register = (k == 24) ? 5'd31 : (k >= 12 && k <= 19) ? rt : s.word[15:11];
      compare_value("decode_program_count", decode_program_count, s.pc);
      compare_value("decode_source_value", decode_source_value, source);
      compare_value("decode_target_value", decode_target_value, target);
      compare_value("decode_immediate", 32'(decode_immediate), 32'(s.word[15:0]));
      compare_value("decode_write_register", 32'(decode_write_register), 32'(write_register));
      compare_value("decode_register_write", 32'(decode_register_write),
                    32'(!(k inside {11, 20, 21, 22, 23})));
      compare_value("decode_memory_write", 32'(decode_memory_write), 32'(k == 20));
      compare_value("decode_is_load", 32'(decode_is_load), 32'(k == 19));
      compare_value("decode_alu_operation", 32'(decode_alu_operation),
                    (bit_index < 0) ? 32'd0 : 32'd1 << bit_index);
      compare_value("decode_source1_is_shift_amount", 32'(decode_source1_is_shift_amount),
                    32'(k >= 8 && k <= 10));
      compare_value("decode_source1_is_program_count", 32'(decode_source1_is_program_count),
                    32'(k == 24));
      compare_value("decode_source2_is_immediate", 32'(decode_source2_is_immediate),
                    32'(k >= 12 && k <= 20));
      compare_value("decode_source2_is_unsigned", 32'(decode_source2_is_unsigned),
                    32'(k >= 13 && k <= 15));
      compare_value("decode_source2_is_8", 32'(decode_source2_is_8), 32'(k == 24));
    end
  endtask

  // Updates the shadow register file and then the pipeline register, as the rising edge does.
  task automatic advance_model();
    staged_t s;
    if (wb_valid && wb_write_register != 5'd0) shadow[wb_write_register] = wb_write_data;
    if (expected_allow_in) begin
      stage.delete();
      if (if_valid) begin
        s.kind = 5'(current_kind);
        s.word = if_instruction;
        s.pc = if_program_count;
        stage.push_back(s);
        accepted++;
      end
    end
  endtask

  initial begin
    int cycles;
    void'($urandom(32'haae9));
    reset = 1'b1;
    if_valid = 1'b0;
    if_instruction = '0;
    if_program_count = '0;
    ex_allow_in = 1'b1;
    ex_valid = 1'b0;
    ex_data_valid = 1'b0;
    ex_write_register = '0;
    ex_write_data = '0;
    wb_valid = 1'b0;
    wb_write_register = '0;
    wb_write_data = '0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    #2;
    check_outputs(); // Empty stage right after reset.
    @(posedge clock);
    advance_model();
    #1;
    cycles = 0;
    while (accepted < INSTRUCTION_COUNT) begin
      if (cycles == CYCLE_LIMIT) report_timeout("the stage stopped accepting instructions");
      drive_inputs();
      #2;
      check_outputs();
      @(posedge clock);
      advance_model();
      #1;
      cycles++;
    end
    if_valid = 1'b0;
    ex_valid = 1'b0;
    wb_valid = 1'b0;
    ex_allow_in = 1'b1;
    cycles = 0;
    while (stage.size() != 0) begin
      if (cycles == DRAIN_LIMIT) report_timeout("the last instruction never left the stage");
      #2;
      check_outputs();
      @(posedge clock);
      advance_model();
      #1;
      cycles++;
    end
    #2;
    check_outputs();
    $display("Test OK");
    $finish;
  end
endmodule
